//--- filelist.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/control_logic.sv
verilog/issue_stage.sv
verilog/decode_queue.sv
verilog/execute_unit.sv
verilog/cpu_slice_top.sv
dv/cpu_slice_assertions.sv
dv/cpu_slice_tb.sv

//--- dv/cpu_slice_tb.sv
// CPU slice testbench
module cpu_slice_tb;

	localparam int N_RANDOM = 24;
	localparam int N_STALL  = pipe_pkg::QUEUE_DEPTH + 1;	// Retire register plus full queue

	logic              clk;
	logic              rst_n;
	logic [15:0]       instr;
	logic              instr_valid;
	logic              instr_ready;
	logic              retire_valid;
	pipe_pkg::retire_t retire;
	logic              retire_ready;

	logic [15:0]       m_regs [16];	// Reference state
	logic [15:0]       m_mem [16];
	logic              fz;
	logic              fn;
	logic              fv;
	pipe_pkg::retire_t expected [$];
	logic [15:0]       prog [$];
	integer            seed = 46;
	int                check_errors = 0;
	logic              hold_stall = 1'b0;
	logic              ready_next = 1'b1;

	cpu_slice_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.retire_valid (retire_valid),
		.retire       (retire),
		.retire_ready (retire_ready)
	);

	bind cpu_slice_top cpu_slice_assertions i_assertions (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_ready   (instr_ready),
		.issue_valid   (issue_valid),
		.credit_return (credit_return),
		.pop           (pop),
		.credits       (i_issue.credits),
		.count         (i_queue.count),
		.retire_valid  (retire_valid),
		.retire_ready  (retire_ready),
		.retire        (retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] enc(isa_pkg::opcode_e op, logic [3:0] a, logic [3:0] b,
	                                    logic [3:0] c);
		return {op, a, b, c};
	endfunction

	// Reference execution, in accept order
	task automatic apply_model(input logic [15:0] ins);
		pipe_pkg::retire_t r;
		isa_pkg::opcode_e  op;
		logic [15:0]       a;
		logic [15:0]       b;
		logic [15:0]       res;
		logic [3:0]        imm4;
		logic [3:0]        addr;
		logic [7:0]        imm8;
		op   = isa_pkg::opcode_e'(ins[15:12]);
		imm4 = ins[3:0];
		imm8 = ins[7:0];
		a    = m_regs[ins[7:4]];
		b    = (op == isa_pkg::INC) ? {{12{imm4[3]}}, imm4} : m_regs[ins[3:0]];
		addr = a[3:0] + imm4;
		r        = '0;
		r.opcode = op;
		r.rd     = ins[11:8];
		r.wen    = op <= isa_pkg::LW || op == isa_pkg::LHB || op == isa_pkg::LLB;
		case (op)
			isa_pkg::ADD, isa_pkg::INC: res = a + b;
			isa_pkg::SUB:  res = a - b;
			isa_pkg::NAND: res = ~(a & b);
			isa_pkg::XOR:  res = a ^ b;
			isa_pkg::SRA:  res = $signed(a) >>> imm4;
			isa_pkg::SRL:  res = a >> imm4;
			isa_pkg::SLL:  res = a << imm4;
			isa_pkg::LW:   res = m_mem[addr];
			isa_pkg::SW:   res = m_regs[ins[11:8]];	// Store data from rd field
			isa_pkg::LHB:  res = {imm8, m_regs[ins[11:8]][7:0]};
			isa_pkg::LLB:  res = {{8{imm8[7]}}, imm8};
			default:       res = '0;
		endcase
		if (op == isa_pkg::B) begin
			case (isa_pkg::branch_cond_e'(ins[11:9]))
				isa_pkg::EQ: r.taken = fz;
				isa_pkg::LT: r.taken = fn;
				isa_pkg::GT: r.taken = !fz && !fn;
				isa_pkg::OV: r.taken = fv;
				isa_pkg::NE: r.taken = !fz;
				isa_pkg::GE: r.taken = !fn;
				isa_pkg::LE: r.taken = fn || fz;
				default:     r.taken = 1'b1;
			endcase
		end
		if (op <= isa_pkg::SLL) begin
			fz = (res == '0);
			fn = res[15];
		end
		if (op == isa_pkg::SUB) begin
			fv = (a[15] != b[15]) && (res[15] != a[15]);
		end else if (op == isa_pkg::ADD || op == isa_pkg::INC) begin
			fv = (a[15] == b[15]) && (res[15] != a[15]);
		end
		r.wdata = res;
		if (r.wen) begin
			m_regs[ins[11:8]] = res;
		end
		if (op == isa_pkg::SW) begin
			m_mem[addr] = res;
			r.mem_wen   = 1'b1;
		end
		if (op == isa_pkg::LW || op == isa_pkg::SW) begin
			r.mem_addr = addr;
		end
		r.err = (op == isa_pkg::ERR);
		expected.push_back(r);
	endtask

	task automatic compare_field(input string name, input logic [15:0] got,
	                             input logic [15:0] exp);
		assert (got === exp) else begin
			check_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// Random gaps, then hold until accepted
	task automatic send(input logic [15:0] ins);
		while (($random(seed) & 3) == 0) begin
			instr_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		instr       = ins;
		instr_valid = 1'b1;
		while (!instr_ready) begin
			@(posedge clk);
			#1;
		end
		apply_model(ins);
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic drain();
		while (expected.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic load_program();
		prog.push_back(enc(isa_pkg::LLB, 4'd1, 4'h3, 4'h5));
		prog.push_back(enc(isa_pkg::LHB, 4'd1, 4'h1, 4'h2));	// r1 = 0x1235
		prog.push_back(enc(isa_pkg::LLB, 4'd2, 4'hf, 4'h0));
		prog.push_back(enc(isa_pkg::LHB, 4'd2, 4'h7, 4'hf));	// r2 = 0x7ff0
		prog.push_back(enc(isa_pkg::LLB, 4'd3, 4'h8, 4'h0));	// Negative
		prog.push_back(enc(isa_pkg::ADD, 4'd4, 4'd1, 4'd2));	// Overflows
		prog.push_back(enc(isa_pkg::B, {isa_pkg::OV, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::SUB, 4'd5, 4'd3, 4'd1));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::LT, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::NAND, 4'd6, 4'd1, 4'd2));
		prog.push_back(enc(isa_pkg::XOR, 4'd7, 4'd1, 4'd3));
		prog.push_back(enc(isa_pkg::INC, 4'd8, 4'd1, 4'hf));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::GT, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::SRA, 4'd9, 4'd3, 4'd3));
		prog.push_back(enc(isa_pkg::SRL, 4'd10, 4'd3, 4'd4));
		prog.push_back(enc(isa_pkg::SLL, 4'd11, 4'd1, 4'd5));
		prog.push_back(enc(isa_pkg::SUB, 4'd12, 4'd1, 4'd1));	// Zero result
		prog.push_back(enc(isa_pkg::B, {isa_pkg::EQ, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::NE, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::GE, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::LE, 1'b1}, 4'h2, 4'h1));
		prog.push_back(enc(isa_pkg::SW, 4'd1, 4'd2, 4'd3));	// mem[3] = r1
		prog.push_back(enc(isa_pkg::LW, 4'd13, 4'd2, 4'd3));
		prog.push_back(enc(isa_pkg::B, {isa_pkg::TR, 1'b0}, 4'h0, 4'h0));
		prog.push_back(enc(isa_pkg::CALL, 4'd0, 4'd0, 4'd0));
		prog.push_back(enc(isa_pkg::RET, 4'd0, 4'd0, 4'd0));
		prog.push_back(enc(isa_pkg::ERR, 4'd13, 4'd1, 4'd1));
		prog.push_back(enc(isa_pkg::ADD, 4'd15, 4'd13, 4'd12));	// ERR left r13 alone
	endtask

	task automatic print_counts();
		$display("Error counts: %0d check, %0d assertion", check_errors,
		         i_dut.i_assertions.failures);
	endtask

	// Compare each record the outside takes
	initial begin
		pipe_pkg::retire_t exp_r;
		forever begin
			@(negedge clk);
			if (rst_n && retire_valid && retire_ready) begin
				assert (expected.size() != 0) else begin
					check_errors++;
					$display("Retire record seen with no instruction pending");
				end
				if (expected.size() != 0) begin
					exp_r = expected.pop_front();
					compare_field("retire.opcode", retire.opcode, exp_r.opcode);
					compare_field("retire.wen", retire.wen, exp_r.wen);
					compare_field("retire.rd", retire.rd, exp_r.rd);
					compare_field("retire.wdata", retire.wdata, exp_r.wdata);
					compare_field("retire.mem_wen", retire.mem_wen, exp_r.mem_wen);
					compare_field("retire.mem_addr", retire.mem_addr, exp_r.mem_addr);
					compare_field("retire.taken", retire.taken, exp_r.taken);
					compare_field("retire.err", retire.err, exp_r.err);
				end
			end
		end
	end

	// Back-pressure, drawn half a cycle before use
	initial begin
		int stall_left;
		stall_left = 0;
		forever begin
			@(posedge clk);
			#1;
			retire_ready = ready_next;
			#1;
			if (hold_stall) begin
				ready_next = 1'b0;	// Queue fill phase
			end else if (stall_left > 0) begin
				stall_left--;
				ready_next = 1'b0;
			end else if (($random(seed) & 7) == 0) begin
				stall_left = 4 + ($random(seed) & 7);	// Long stall
				ready_next = 1'b0;
			end else begin
				ready_next = 1'b1;
			end
		end
	end

	initial begin
		@(posedge clk);
		repeat ((prog.size() + N_STALL + N_RANDOM) * 40 + 200) @(posedge clk);
		$display("Watchdog expired before all instructions retired");
		print_counts();
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		rst_n        = 1'b0;
		instr        = '0;
		instr_valid  = 1'b0;
		retire_ready = 1'b0;
		fz           = 1'b0;
		fn           = 1'b0;
		fv           = 1'b0;
		foreach (m_regs[i]) m_regs[i] = '0;
		foreach (m_mem[i]) m_mem[i] = '0;
		load_program();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		assert (!retire_valid && instr_ready) else begin
			check_errors++;
			$display("Outputs not idle after reset");
		end
		foreach (prog[i]) send(prog[i]);
		drain();
		hold_stall = 1'b1;
		@(posedge clk);
		#1;
		repeat (N_STALL) send(enc(isa_pkg::INC, 4'd14, 4'd14, 4'd1));	// Counter in r14
		repeat (4) begin
			@(posedge clk);
			#1;
		end
		assert (!instr_ready) else begin
			check_errors++;
			$display("instr_ready still high with the queue full");
		end
		hold_stall = 1'b0;
		repeat (N_RANDOM) begin
			rnd = $random(seed);
			send(rnd[15:0]);
		end
		drain();
		print_counts();
		if (check_errors == 0 && i_dut.i_assertions.failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- dv/cpu_slice_assertions.sv
// Credit, queue and retire checks
module cpu_slice_assertions (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          instr_ready,
	input logic                          issue_valid,
	input logic                          credit_return,
	input logic                          pop,
	input logic [pipe_pkg::CREDIT_W-1:0] credits,
	input logic [pipe_pkg::CREDIT_W-1:0] count,
	input logic                          retire_valid,
	input logic                          retire_ready,
	input pipe_pkg::retire_t             retire
);

	int failures = 0;

	credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= pipe_pkg::QUEUE_DEPTH)
		else begin failures++; $error("credit count above queue depth"); end

	// Every credit sits in the counter, the issue register, the queue or a return pulse
	credit_balance: assert property (@(posedge clk) disable iff (!rst_n)
		int'(credits) + int'(issue_valid) + int'(count) + int'(credit_return)
			== pipe_pkg::QUEUE_DEPTH)
		else begin failures++; $error("credits lost or created"); end

	queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> (count < pipe_pkg::QUEUE_DEPTH) || pop)
		else begin failures++; $error("write into a full queue"); end

	credit_per_pop: assert property (@(posedge clk) disable iff (!rst_n)
		credit_return == $past(pop))
		else begin failures++; $error("credit return does not follow pop"); end

	retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire))
		else begin failures++; $error("retire record changed while stalled"); end

	// Idle outputs right after a reset edge
	reset_state: assert property (@(posedge clk)
		!rst_n |=> !retire_valid && instr_ready && !credit_return && !pop)
		else begin failures++; $error("outputs not idle after reset"); end

endmodule

//--- verilog/cpu_slice_top.sv
// Decode and execute slice
module cpu_slice_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [isa_pkg::DATA_W-1:0] instr,
	input  logic                       instr_valid,
	output logic                       instr_ready,
	output logic                       retire_valid,
	output pipe_pkg::retire_t          retire,
	input  logic                       retire_ready
);

	logic             issue_valid;
	pipe_pkg::issue_t issue;
	logic             credit_return;
	logic             head_valid;
	pipe_pkg::issue_t head;
	logic             pop;

	issue_stage i_issue (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.credit_return (credit_return)
	);

	decode_queue i_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.credit_return (credit_return),
		.head_valid    (head_valid),
		.head          (head),
		.pop           (pop)
	);

	execute_unit i_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.head_valid   (head_valid),
		.head         (head),
		.pop          (pop),
		.retire_valid (retire_valid),
		.retire       (retire),
		.retire_ready (retire_ready)
	);

endmodule

//--- verilog/execute_unit.sv
// Execute and retire
module execute_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              head_valid,
	input  pipe_pkg::issue_t  head,
	output logic              pop,
	output logic              retire_valid,
	output pipe_pkg::retire_t retire,
	input  logic              retire_ready
);

	logic [isa_pkg::DATA_W-1:0]     regs [2**isa_pkg::REG_ADDR_W];
	logic [isa_pkg::DATA_W-1:0]     mem  [2**isa_pkg::MEM_ADDR_W];
	logic                           flag_z;
	logic                           flag_n;
	logic                           flag_v;
	logic [isa_pkg::REG_ADDR_W-1:0] rd;
	logic [isa_pkg::REG_ADDR_W-1:0] rs;
	logic [isa_pkg::REG_ADDR_W-1:0] rt;
	logic [3:0]                     imm4;
	logic [isa_pkg::IMM8_W-1:0]     imm8;
	logic [isa_pkg::DATA_W-1:0]     imm_ext;
	logic [isa_pkg::DATA_W-1:0]     op_a;
	logic [isa_pkg::DATA_W-1:0]     op_b;
	logic [isa_pkg::DATA_W-1:0]     alu_res;
	logic [isa_pkg::DATA_W-1:0]     wdata;
	logic [isa_pkg::MEM_ADDR_W-1:0] addr;
	isa_pkg::branch_cond_e          cond;
	logic                           alu_v;
	logic                           cond_true;
	logic                           alu_group;
	logic                           v_group;

	assign rd   = head.instr[11:8];
	assign rs   = head.instr[7:4];
	assign rt   = head.ctrl.reg_rt_src ? head.instr[11:8] : head.instr[3:0];
	assign imm4 = head.instr[3:0];
	assign imm8 = head.instr[isa_pkg::IMM8_W-1:0];
	assign cond = isa_pkg::branch_cond_e'(head.instr[11:9]);

	assign imm_ext = head.ctrl.sign_ext_sel ? {{(isa_pkg::DATA_W-4){imm4[3]}}, imm4}
	                                        : {{(isa_pkg::DATA_W-4){1'b0}}, imm4};
	assign op_a    = regs[rs];
	assign op_b    = head.ctrl.alu_src ? imm_ext : regs[rt];
	assign addr    = op_a[isa_pkg::MEM_ADDR_W-1:0] + imm4;	// Wraps mod 16

	assign alu_group = !head.opcode[isa_pkg::OPCODE_W-1];	// Opcodes 0 to 7
	assign v_group   = head.ctrl.alu_op inside {isa_pkg::ALU_ADD, isa_pkg::ALU_SUB, isa_pkg::ALU_INC};

	// Retire slot free or draining this cycle
	assign pop = head_valid && (!retire_valid || retire_ready);

	always_comb begin
		alu_res = '0;
		alu_v   = 1'b0;
		case (head.ctrl.alu_op)
			isa_pkg::ALU_ADD, isa_pkg::ALU_INC: begin
				alu_res = op_a + op_b;
				alu_v   = (op_a[isa_pkg::SIGN_BIT] == op_b[isa_pkg::SIGN_BIT]) &&
				          (alu_res[isa_pkg::SIGN_BIT] != op_a[isa_pkg::SIGN_BIT]);
			end
			isa_pkg::ALU_SUB: begin
				alu_res = op_a - op_b;
				alu_v   = (op_a[isa_pkg::SIGN_BIT] != op_b[isa_pkg::SIGN_BIT]) &&
				          (alu_res[isa_pkg::SIGN_BIT] != op_a[isa_pkg::SIGN_BIT]);
			end
			isa_pkg::ALU_NAND: alu_res = ~(op_a & op_b);
			isa_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
			isa_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> imm4;
			isa_pkg::ALU_SRL:  alu_res = op_a >> imm4;
			default:           alu_res = op_a << imm4;	// SLL
		endcase
	end

	always_comb begin
		if (head.ctrl.mem_to_reg) begin
			wdata = mem[addr];
		end else if (head.ctrl.reg_to_mem) begin
			wdata = regs[rt];
		end else if (head.opcode == isa_pkg::LHB) begin
			wdata = {imm8, regs[rd][isa_pkg::IMM8_W-1:0]};	// Keep low byte
		end else if (head.opcode == isa_pkg::LLB) begin
			wdata = {{(isa_pkg::DATA_W-isa_pkg::IMM8_W){imm8[isa_pkg::IMM8_W-1]}}, imm8};
		end else if (head.ctrl.reg_write) begin
			wdata = alu_res;
		end else begin
			wdata = '0;
		end
	end

	// Condition on flags left by the last ALU op
	always_comb begin
		case (cond)
			isa_pkg::EQ: cond_true = flag_z;
			isa_pkg::LT: cond_true = flag_n;
			isa_pkg::GT: cond_true = !flag_z && !flag_n;
			isa_pkg::OV: cond_true = flag_v;
			isa_pkg::NE: cond_true = !flag_z;
			isa_pkg::GE: cond_true = !flag_n;
			isa_pkg::LE: cond_true = flag_n || flag_z;
			default:     cond_true = 1'b1;	// TR
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**isa_pkg::REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
			for (int i = 0; i < 2**isa_pkg::MEM_ADDR_W; i++) begin
				mem[i] <= '0;
			end
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else if (pop) begin
			if (head.ctrl.reg_write) begin
				regs[rd] <= wdata;
			end
			if (head.ctrl.reg_to_mem) begin
				mem[addr] <= regs[rt];
			end
			if (alu_group) begin
				flag_z <= (alu_res == '0);
				flag_n <= alu_res[isa_pkg::SIGN_BIT];
				if (v_group) begin
					flag_v <= alu_v;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
		end else if (pop) begin
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	// Record held until the outside takes it
	always_ff @(posedge clk) begin
		if (pop) begin
			retire.opcode   <= head.opcode;
			retire.wen      <= head.ctrl.reg_write;
			retire.rd       <= rd;
			retire.wdata    <= wdata;
			retire.mem_wen  <= head.ctrl.reg_to_mem;
			retire.mem_addr <= head.ctrl.data_reg ? addr : '0;
			retire.taken    <= head.ctrl.branch && cond_true;
			retire.err      <= head.ctrl.err;
		end
	end

endmodule

//--- verilog/decode_queue.sv
// Decoded instruction FIFO with credit return
module decode_queue (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             issue_valid,
	input  pipe_pkg::issue_t issue,
	output logic             credit_return,
	output logic             head_valid,
	output pipe_pkg::issue_t head,
	input  logic             pop
);

	pipe_pkg::issue_t                 entries [pipe_pkg::QUEUE_DEPTH];
	logic [pipe_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [pipe_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [pipe_pkg::CREDIT_W-1:0]    count;
	logic                             do_pop;

	assign head_valid = (count != '0);
	assign head       = entries[rd_ptr];
	assign do_pop     = pop && head_valid;

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			entries[wr_ptr] <= issue;
		end
	end

	// Pointers wrap naturally at depth 4
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop;	// One pulse per pop
			if (issue_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({issue_valid, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/issue_stage.sv
// Instruction issue with credit flow control
module issue_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [isa_pkg::DATA_W-1:0] instr,
	input  logic                       instr_valid,
	output logic                       instr_ready,
	output logic                       issue_valid,
	output pipe_pkg::issue_t           issue,
	input  logic                       credit_return
);

	logic [pipe_pkg::CREDIT_W-1:0] credits;
	isa_pkg::opcode_e              opcode;
	pipe_pkg::ctrl_t               ctrl;
	logic                          accept;

	assign opcode      = isa_pkg::opcode_e'(instr[isa_pkg::DATA_W-1 -: isa_pkg::OPCODE_W]);
	assign instr_ready = (credits != '0);
	assign accept      = instr_valid && instr_ready;

	control_logic i_control (
		.opcode (opcode),
		.ctrl   (ctrl)
	);

	// Credit is spent at accept, so a held issue entry already owns its slot
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= pipe_pkg::QUEUE_DEPTH[pipe_pkg::CREDIT_W-1:0];
		end else begin
			case ({accept, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			issue.opcode <= opcode;
			issue.instr  <= instr;
			issue.ctrl   <= ctrl;
		end
	end

endmodule

//--- verilog/control_logic.sv
// Opcode to control word decoder
module control_logic (
	input  isa_pkg::opcode_e opcode,
	output pipe_pkg::ctrl_t  ctrl
);

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = isa_pkg::alu_op_e'(opcode[2:0]);
		case (opcode)
			isa_pkg::ADD, isa_pkg::SUB, isa_pkg::NAND, isa_pkg::XOR,
			isa_pkg::SRA, isa_pkg::SRL, isa_pkg::SLL: begin
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::INC: begin
				ctrl.alu_src      = 1'b1;	// rs plus signed imm4
				ctrl.sign_ext_sel = 1'b1;
				ctrl.reg_write    = 1'b1;
			end
			isa_pkg::LW: begin
				ctrl.data_reg   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			isa_pkg::SW: begin
				ctrl.data_reg   = 1'b1;
				ctrl.reg_to_mem = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.reg_rt_src = 1'b1;	// Store data sits in rd field
			end
			isa_pkg::LHB, isa_pkg::LLB: begin
				ctrl.reg_write = 1'b1;
			end
			isa_pkg::B: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = isa_pkg::ALU_ADD;	// ALU idle on branches
			end
			isa_pkg::CALL: begin
				ctrl.call = 1'b1;
			end
			isa_pkg::RET: begin
				ctrl.rtrn = 1'b1;
			end
			default: begin
				// ERR carries only its flag
				ctrl     = '0;
				ctrl.err = 1'b1;
			end
		endcase
	end

endmodule

//--- verilog/pipe_pkg.sv
// Pipeline payload types
package pipe_pkg;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = 2;
	localparam int CREDIT_W    = 3;	// Counts 0 to QUEUE_DEPTH

	typedef struct packed {
		logic             data_reg;	// Address from rs plus imm4
		logic             call;
		logic             rtrn;
		logic             branch;
		logic             mem_to_reg;
		logic             reg_to_mem;
		isa_pkg::alu_op_e alu_op;
		logic             alu_src;	// Immediate as second operand
		logic             sign_ext_sel;
		logic             reg_rt_src;	// Second read port from rd field
		logic             reg_write;
		logic             err;
	} ctrl_t;

	// Queue entry
	typedef struct packed {
		isa_pkg::opcode_e           opcode;
		logic [isa_pkg::DATA_W-1:0] instr;
		ctrl_t                      ctrl;
	} issue_t;

	typedef struct packed {
		isa_pkg::opcode_e               opcode;
		logic                           wen;
		logic [isa_pkg::REG_ADDR_W-1:0] rd;
		logic [isa_pkg::DATA_W-1:0]     wdata;	// Store data on SW
		logic                           mem_wen;
		logic [isa_pkg::MEM_ADDR_W-1:0] mem_addr;
		logic                           taken;
		logic                           err;
	} retire_t;

endpackage

//--- verilog/isa_pkg.sv
// Teaching ISA definitions
package isa_pkg;

	localparam int OPCODE_W   = 4;
	localparam int ALU_OP_W   = 3;
	localparam int COND_W     = 3;
	localparam int DATA_W     = 16;
	localparam int SIGN_BIT   = DATA_W - 1;
	localparam int REG_ADDR_W = 4;
	localparam int MEM_ADDR_W = 4;	// 16-word data memory
	localparam int IMM8_W     = 8;

	// Opcode field, instr[15:12]
	typedef enum logic [OPCODE_W-1:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		NAND = 4'd2,
		XOR  = 4'd3,
		INC  = 4'd4,
		SRA  = 4'd5,
		SRL  = 4'd6,
		SLL  = 4'd7,
		LW   = 4'd8,
		SW   = 4'd9,
		LHB  = 4'd10,
		LLB  = 4'd11,
		B    = 4'd12,
		CALL = 4'd13,
		RET  = 4'd14,
		ERR  = 4'd15
	} opcode_e;

	// Same as the low three opcode bits
	typedef enum logic [ALU_OP_W-1:0] {
		ALU_ADD, ALU_SUB, ALU_NAND, ALU_XOR, ALU_INC, ALU_SRA, ALU_SRL, ALU_SLL
	} alu_op_e;

	typedef enum logic [COND_W-1:0] {
		EQ, LT, GT, OV, NE, GE, LE, TR
	} branch_cond_e;

endpackage
